/* zx_bus_core.f */
common/zx_arch_pkg.sv
common/zx_bus_pkg.sv
src/io_decode.sv
paging/paging_regs.sv
paging/memory_map.sv
src/ula_io.sv
src/zx_bus_core.sv
tests/zx_bus_checker.sv
tests/tb_zx_bus_core.sv

/* tests/tb_zx_bus_core.sv */
// Testbench top for the bus core with clock, reset, LFSR bus stimulus, DUT and checker
`timescale 1ns/1ps

module tb_zx_bus_core;

	logic                 clk_sys;
	logic                 reset;
	zx_bus_pkg::cpu_bus_t cpu_bus;
	zx_arch_pkg::model_t  machine;
	logic [4:0]           key_data;
	logic                 tape_in;
	logic [7:0]           ram_dout;
	zx_bus_pkg::mem_req_t mem_req;
	logic [7:0]           cpu_din;
	logic [2:0]           border;
	logic                 ear;
	logic                 mic;

	int          error_count;
	int          check_count;
	int          issued;    // bus cycles sent so far
	logic        timed_out;
	logic [31:0] lfsr;

	zx_bus_core i_dut (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_bus  (cpu_bus),
		.cpu_din  (cpu_din),
		.machine  (machine),
		.key_data (key_data),
		.tape_in  (tape_in),
		.ram_dout (ram_dout),
		.mem_req  (mem_req),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

	zx_bus_checker i_chk (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_bus     (cpu_bus),
		.machine     (machine),
		.key_data    (key_data),
		.tape_in     (tape_in),
		.ram_dout    (ram_dout),
		.mem_req     (mem_req),
		.cpu_din     (cpu_din),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.error_count (error_count),
		.check_count (check_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys; // 100 ns period
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic zx_arch_pkg::model_t pick_model(input int idx);
		case (idx)
			0:       return zx_arch_pkg::ZX128;
			1:       return zx_arch_pkg::ZX48;
			2:       return zx_arch_pkg::PENT1024;
			3:       return zx_arch_pkg::PROFI1024;
			default: return zx_arch_pkg::PLUS3;
		endcase
	endfunction

	task automatic apply_reset(input zx_arch_pkg::model_t m);
		@(posedge clk_sys);
		#10;
		machine = m;
		reset   = 1'b1;
		repeat (5) @(posedge clk_sys);
		#10;
		reset = 1'b0;
	endtask

	// Waits until the checker has compared the last cycle
	task automatic wait_checked();
		int waited;
		waited = 0;
		while (check_count != issued && waited < 8) begin
			@(posedge clk_sys);
			waited++;
		end
		if (check_count != issued) begin
			$display("Timeout: checker did not compare bus cycle %0d", issued);
			timed_out = 1'b1;
		end
	endtask

	// =====================
	// Bus cycles
	// =====================

	// Three active clocks then one idle clock
	task automatic run_bus_cycle();
		zx_bus_pkg::cpu_bus_t b;
		logic [2:0]           kind;
		b      = '0;
		b.addr = 16'(rand_bits(16));
		b.dout = 8'(rand_bits(8));
		kind   = 3'(rand_bits(3));
		if (rand_bits(3) != 3'd0)
			b.dout[5] = 1'b0; // keep the 7FFD lock rare
		case (kind)
			3'd0, 3'd1, 3'd2: begin
				b.mreq = 1'b1;
				b.rd   = 1'b1;
				b.m1   = 1'(rand_bits(1));
			end
			3'd3, 3'd4: begin
				b.mreq = 1'b1;
				b.wr   = 1'b1;
			end
			3'd5, 3'd6: begin
				b.iorq = 1'b1;
				b.wr   = 1'b1;
				case (rand_bits(3))
					3'd0:    b.addr = 16'h7FFD;
					3'd1:    b.addr = 16'h1FFD;
					3'd2:    b.addr = 16'hEFF7;
					3'd3:    b.addr = 16'hDFFD;
					3'd4:    b.addr = {8'(rand_bits(8)), 8'hFE};
					default: ; // random port
				endcase
			end
			default: begin
				b.iorq = 1'b1;
				b.rd   = 1'b1;
			end
		endcase
		@(posedge clk_sys);
		#10;
		cpu_bus  = b;
		ram_dout = 8'(rand_bits(8));
		key_data = 5'(rand_bits(5));
		tape_in  = 1'(rand_bits(1));
		repeat (3) @(posedge clk_sys);
		#10;
		cpu_bus = '0;
		issued++;
		wait_checked();
	endtask

	initial begin
		lfsr      = 32'd97482;
		reset     = 1'b1;
		cpu_bus   = '0;
		machine   = zx_arch_pkg::ZX128;
		key_data  = 5'h1F;
		tape_in   = 1'b0;
		ram_dout  = 8'h00;
		issued    = 0;
		timed_out = 1'b0;

		for (int p = 0; p < 5 && !timed_out; p++) begin
			apply_reset(pick_model(p));
			for (int n = 0; n < 300 && !timed_out; n++)
				run_bus_cycle();
		end

		$display("Checked %0d bus cycles, %0d errors", check_count, error_count);
		if (error_count == 0 && !timed_out)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

/* tests/zx_bus_checker.sv */
// Bus core checker: reference model of ports, paging and mapping, compares DUT outputs
`timescale 1ns/1ps

module zx_bus_checker (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t cpu_bus,
	input  zx_arch_pkg::model_t  machine,
	input  logic [4:0]           key_data,
	input  logic                 tape_in,
	input  logic [7:0]           ram_dout,
	input  zx_bus_pkg::mem_req_t mem_req,
	input  logic [7:0]           cpu_din,
	input  logic [2:0]           border,
	input  logic                 ear,
	input  logic                 mic,
	output int                   error_count,
	output int                   check_count
);

	zx_arch_pkg::model_t mdl;
	logic [7:0]          r7ffd;
	logic [7:0]          r1ffd;
	logic [7:0]          reff7;
	logic [2:0]          rext;
	logic [2:0]          m_border;
	logic                m_ear;
	logic                m_mic;
	int                  act_cnt; // clocks into the current bus cycle

	initial begin
		error_count = 0;
		check_count = 0;
	end

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			error_count++;
			$display("** Error %s: expected %h, got %h at %0t", name, exp, act, $time);
		end
	endtask

	// Bank order of the four all-RAM layouts, quadrant 0 in the low bits
	function automatic logic [2:0] special_bank(input logic [1:0] layout, input logic [1:0] q);
		logic [11:0] row;
		case (layout)
			2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
			default: row = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return row[q*3 +: 3];
	endfunction

	function automatic logic [20:0] exp_addr(input logic [15:0] a);
		logic [1:0] q;
		logic [3:0] rom;
		logic [5:0] page;
		q = a[15:14];
		if (mdl == zx_arch_pkg::PLUS3 && r1ffd[0])
			return {1'b0, 3'd0, special_bank(r1ffd[2:1], q), a[13:0]};
		if (q == 2'd0) begin
			if (mdl == zx_arch_pkg::PLUS3)
				rom = {zx_arch_pkg::ROM_PLUS3_BASE, r1ffd[2], r7ffd[4]};
			else
				rom = {zx_arch_pkg::ROM_128_BASE, (mdl == zx_arch_pkg::ZX48) | r7ffd[4]};
			return {zx_arch_pkg::ROM_REGION, rom, a[13:0]};
		end
		case (q)
			2'd1:    page = 6'(zx_arch_pkg::BANK_SCREEN);
			2'd2:    page = 6'(zx_arch_pkg::BANK_MID);
			default: page = {rext, r7ffd[2:0]};
		endcase
		return {1'b0, page, a[13:0]};
	endfunction

	// ====================
	// Port write model
	// ====================

	task automatic apply_write(input logic [15:0] a, input logic [7:0] d);
		logic plus3;
		logic p1024;
		logic locked;
		plus3  = (mdl == zx_arch_pkg::PLUS3);
		p1024  = (mdl == zx_arch_pkg::PENT1024);
		locked = (mdl == zx_arch_pkg::ZX48) | (!p1024 & r7ffd[5]) | (p1024 & r7ffd[5] & reff7[2]);
		if (!a[15] && !a[1] && (a[14] || !plus3) && !locked) begin
			if (p1024 && !reff7[2])
				rext = {d[5], d[7], d[6]};
			r7ffd = d;
		end
		if (a[15:12] == 4'b0001 && !a[1] && plus3 && !locked)
			r1ffd = d;
		if (a[15:12] == 4'b1110 && !a[3] && p1024)
			reff7 = d;
		if (a == 16'hDFFD && mdl == zx_arch_pkg::PROFI1024)
			rext = d[2:0];
		if (!a[0]) begin
			m_border = d[2:0];
			m_mic    = d[3];
			m_ear    = d[4];
		end
	endtask

	task automatic compare_outputs();
		logic       special;
		logic [7:0] din;
		special = (mdl == zx_arch_pkg::PLUS3) && r1ffd[0];
		if (cpu_bus.mreq)
			check_value("mem_req.addr", exp_addr(cpu_bus.addr), mem_req.addr);
		check_value("mem_req.we", cpu_bus.mreq & cpu_bus.wr & (special | (cpu_bus.addr[15:14] != 0)),
			mem_req.we);
		check_value("mem_req.rd", cpu_bus.mreq & cpu_bus.rd, mem_req.rd);
		if (cpu_bus.mreq && cpu_bus.rd)
			din = ram_dout;
		else if (cpu_bus.iorq && cpu_bus.rd && !cpu_bus.m1 && !cpu_bus.addr[0])
			din = {1'b1, ~tape_in, 1'b1, key_data}; // keyboard and tape
		else
			din = 8'hFF;
		check_value("cpu_din", din, cpu_din);
		check_value("border", m_border, border);
		check_value("ear", m_ear, ear);
		check_value("mic", m_mic, mic);
		check_count++;
	endtask

	always @(posedge clk_sys) begin
		if (reset) begin
			mdl      = machine;
			r7ffd    = 8'h00;
			r1ffd    = 8'h00;
			reff7    = 8'h00;
			rext     = 3'd0;
			m_border = 3'd0;
			m_ear    = 1'b0;
			m_mic    = 1'b0;
			act_cnt  = 0;
		end else if (cpu_bus.mreq || cpu_bus.iorq) begin
			// Model takes the write at its first clock, DUT shows it by the third
			if (act_cnt == 0 && cpu_bus.iorq && cpu_bus.wr && !cpu_bus.m1)
				apply_write(cpu_bus.addr, cpu_bus.dout);
			if (act_cnt == 2)
				compare_outputs();
			act_cnt++;
		end else begin
			act_cnt = 0;
		end
	end

endmodule

/* src/zx_bus_core.sv */
// Spectrum memory and ULA bus core: port decoding, paging, memory map and ULA port
`timescale 1ns/1ps

module zx_bus_core (
	input  logic                 clk_sys,
	input  logic                 reset,

	// CPU side
	input  zx_bus_pkg::cpu_bus_t cpu_bus,
	output logic [7:0]           cpu_din,

	// Machine select, sampled during reset
	input  zx_arch_pkg::model_t  machine,

	// Keyboard and tape
	input  logic [4:0]           key_data,
	input  logic                 tape_in,

	// External memory
	input  logic [7:0]           ram_dout,
	output zx_bus_pkg::mem_req_t mem_req,

	// ULA outputs
	output logic [2:0]           border,
	output logic                 ear,
	output logic                 mic
);

	zx_bus_pkg::port_wr_t port_wr; // strobes from the decoder
	zx_bus_pkg::paging_t  paging;  // current paging state

	// ====================
	// Port decoding
	// ====================

	io_decode i_io_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cpu_bus (cpu_bus),
		.paging  (paging),
		.port_wr (port_wr)
	);

	// ====================
	// Paging and mapping
	// ====================

	paging_regs i_paging_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.port_wr (port_wr),
		.paging  (paging)
	);

	memory_map i_memory_map (
		.cpu_bus (cpu_bus),
		.paging  (paging),
		.mem_req (mem_req)
	);

	// ULA port and CPU read mux
	ula_io i_ula_io (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_bus  (cpu_bus),
		.port_wr  (port_wr),
		.key_data (key_data),
		.tape_in  (tape_in),
		.ram_dout (ram_dout),
		.cpu_din  (cpu_din),
		.border   (border),
		.ear      (ear),
		.mic      (mic)
	);

endmodule

/* src/ula_io.sv */
// ULA port: border, EAR and MIC outputs, plus the CPU read-data mux
`timescale 1ns/1ps

module ula_io (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t cpu_bus,
	input  zx_bus_pkg::port_wr_t port_wr,
	input  logic [4:0]           key_data, // active low keys of the addressed rows
	input  logic                 tape_in,
	input  logic [7:0]           ram_dout,
	output logic [7:0]           cpu_din,
	output logic [2:0]           border,
	output logic                 ear,
	output logic                 mic
);

	logic mem_rd;
	logic fe_rd;

	// ====================
	// Port FE output
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (port_wr.pfe) begin
			border <= port_wr.data[2:0];
			mic    <= port_wr.data[3];
			ear    <= port_wr.data[4];
		end
	end

	// ====================
	// Read mux
	// ====================

	assign mem_rd = cpu_bus.mreq & cpu_bus.rd;
	// Any even port reads the keyboard and tape
	assign fe_rd  = cpu_bus.iorq & cpu_bus.rd & ~cpu_bus.m1 & ~cpu_bus.addr[0];

	always_comb begin
		if (mem_rd)
			cpu_din = ram_dout;
		else if (fe_rd)
			cpu_din = {1'b1, ~tape_in, 1'b1, key_data};
		else
			cpu_din = 8'hFF; // floating bus
	end

endmodule

/* paging/memory_map.sv */
// Memory map: CPU address to external ROM/RAM address plus read and write enables
`timescale 1ns/1ps

module memory_map (
	input  zx_bus_pkg::cpu_bus_t cpu_bus,
	input  zx_bus_pkg::paging_t  paging,
	output zx_bus_pkg::mem_req_t mem_req
);

	logic [1:0]                     quadrant;
	logic [zx_arch_pkg::PAGE_W-1:0] offset;
	logic                           special;   // +3 all-RAM mode
	logic [1:0]                     layout;    // 1FFD bits 2..1
	logic [3:0]                     rom_bank;
	logic [5:0]                     ram_page;  // 64 pages of 16K
	logic [2:0]                     spec_bank;

	assign quadrant = cpu_bus.addr[15:14];
	assign offset   = cpu_bus.addr[zx_arch_pkg::PAGE_W-1:0];
	assign special  = paging.plus3 & paging.reg_1ffd[0];
	assign layout   = paging.reg_1ffd[2:1];

	// ROM bank select
	always_comb begin
		if (paging.plus3)
			rom_bank = {zx_arch_pkg::ROM_PLUS3_BASE, paging.reg_1ffd[2], paging.reg_7ffd[4]};
		else
			rom_bank = {zx_arch_pkg::ROM_128_BASE, paging.zx48 | paging.reg_7ffd[4]};
	end

	// ====================
	// +3 special layouts
	// ====================

	always_comb begin
		case (layout)
			2'b00:   spec_bank = {1'b0, quadrant};                         // 0 1 2 3
			2'b01:   spec_bank = {1'b1, quadrant};                         // 4 5 6 7
			2'b10:   spec_bank = (quadrant == 2'd3) ? 3'd3 : {1'b1, quadrant}; // 4 5 6 3
			default: begin                                                 // 4 7 6 3
				case (quadrant)
					2'd0:    spec_bank = 3'd4;
					2'd1:    spec_bank = 3'd7;
					2'd2:    spec_bank = 3'd6;
					default: spec_bank = 3'd3;
				endcase
			end
		endcase
	end

	// ====================
	// Address and enables
	// ====================

	always_comb begin
		case (quadrant)
			2'd1:    ram_page = {3'd0, zx_arch_pkg::BANK_SCREEN};
			2'd2:    ram_page = {3'd0, zx_arch_pkg::BANK_MID};
			default: ram_page = {paging.page_ext, paging.reg_7ffd[2:0]}; // upper quadrant
		endcase

		if (special)
			mem_req.addr = {1'b0, 3'd0, spec_bank, offset};
		else if (quadrant == 2'd0)
			mem_req.addr = {zx_arch_pkg::ROM_REGION, rom_bank, offset};
		else
			mem_req.addr = {1'b0, ram_page, offset};

		// ROM is read only outside special mode
		mem_req.we = cpu_bus.mreq & cpu_bus.wr & (special | (quadrant != 2'd0));
		mem_req.rd = cpu_bus.mreq & cpu_bus.rd;
	end

endmodule

/* paging/paging_regs.sv */
// Paging registers for 7FFD, 1FFD, EFF7 and DFFD with lock rule and model latch
`timescale 1ns/1ps

module paging_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_arch_pkg::model_t  machine,
	input  zx_bus_pkg::port_wr_t port_wr,
	output zx_bus_pkg::paging_t  paging
);

	logic [7:0] reg_7ffd;
	logic [7:0] reg_1ffd;
	logic [2:0] page_ext;
	logic       eff7_lock; // EFF7 bit 2 turns off the 1024K extension on Pentagon

	logic zx48;
	logic plus3;
	logic p1024;
	logic pf1024;

	logic page_disable;

	// ====================
	// Lock rule
	// ====================

	// 48K never pages; elsewhere 7FFD bit 5 locks, except on Pentagon 1024
	// where it only counts once the extension is switched off
	assign page_disable = zx48
		| (~p1024 & reg_7ffd[5])
		| (p1024 & eff7_lock & reg_7ffd[5]);

	// ====================
	// Model flags
	// ====================

	// Latched on every clock while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48   <= (machine == zx_arch_pkg::ZX48);
			plus3  <= (machine == zx_arch_pkg::PLUS3);
			p1024  <= (machine == zx_arch_pkg::PENT1024);
			pf1024 <= (machine == zx_arch_pkg::PROFI1024);
		end
	end

	// ====================
	// Paging registers
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			reg_7ffd  <= 8'h00;
			reg_1ffd  <= 8'h00;
			page_ext  <= 3'd0;
			eff7_lock <= 1'b0;
		end else begin
			if (port_wr.p7ffd & ~page_disable) begin
				reg_7ffd <= port_wr.data;
				// Pentagon puts the extra page bits in 7FFD bits 5,7,6
				if (p1024 & ~eff7_lock)
					page_ext <= {port_wr.data[5], port_wr.data[7:6]};
			end

			if (port_wr.p1ffd & ~page_disable)
				reg_1ffd <= port_wr.data;

			if (port_wr.peff7)
				eff7_lock <= port_wr.data[2];

			// Decoder only strobes DFFD on Profi 1024
			if (port_wr.pdffd)
				page_ext <= port_wr.data[2:0];
		end
	end

	// Pack the state for the map and the decoder
	always_comb begin
		paging.reg_7ffd = reg_7ffd;
		paging.reg_1ffd = reg_1ffd;
		paging.page_ext = page_ext;
		paging.zx48     = zx48;
		paging.plus3    = plus3;
		paging.p1024    = p1024;
		paging.pf1024   = pf1024;
	end

endmodule

/* src/io_decode.sv */
// I/O write decoder that finds the start of each port write and turns it into one-cycle strobes
`timescale 1ns/1ps

module io_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_bus_pkg::cpu_bus_t cpu_bus,
	input  zx_bus_pkg::paging_t  paging,
	output zx_bus_pkg::port_wr_t port_wr
);

	logic        io_wr;    // I/O write in progress without M1
	logic        io_wr_q;  // previous state
	logic        wr_edge;
	logic [15:0] a;

	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;
	logic sel_dffd;
	logic sel_fe;

	assign a       = cpu_bus.addr;
	assign io_wr   = cpu_bus.iorq & cpu_bus.wr & ~cpu_bus.m1;
	assign wr_edge = io_wr & ~io_wr_q;

	// ====================
	// Port selects
	// ====================

	// +3 needs A14 high for 7FFD, so 1FFD stays distinct
	assign sel_7ffd = ~a[15] & ~a[1] & (a[14] | ~paging.plus3);
	assign sel_1ffd = ~a[15] & ~a[14] & ~a[13] & a[12] & ~a[1] & paging.plus3;
	assign sel_eff7 = a[15] & a[14] & a[13] & ~a[12] & ~a[3] & paging.p1024;
	assign sel_dffd = (a == 16'hDFFD) & paging.pf1024; // fully decoded
	assign sel_fe   = ~a[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q       <= 1'b0;
			port_wr.p7ffd <= 1'b0;
			port_wr.p1ffd <= 1'b0;
			port_wr.peff7 <= 1'b0;
			port_wr.pdffd <= 1'b0;
			port_wr.pfe   <= 1'b0;
		end else begin
			io_wr_q       <= io_wr;
			port_wr.p7ffd <= wr_edge & sel_7ffd;
			port_wr.p1ffd <= wr_edge & sel_1ffd;
			port_wr.peff7 <= wr_edge & sel_eff7;
			port_wr.pdffd <= wr_edge & sel_dffd;
			port_wr.pfe   <= wr_edge & sel_fe;
		end

		// Data rides along with the strobes
		if (wr_edge)
			port_wr.data <= cpu_bus.dout;
	end

endmodule

/* common/zx_bus_pkg.sv */
// Bus-side types: CPU bus, port write strobes, paging state and memory request
package zx_bus_pkg;

	// ====================
	// CPU bus
	// ====================

	// Z80 bus with all strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout; // CPU write data
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// ====================
	// Port writes
	// ====================

	// One strobe per decoded I/O write, each high for one clock
	typedef struct packed {
		logic       p7ffd;
		logic       p1ffd;
		logic       peff7; // Pentagon 1024 config
		logic       pdffd; // Profi 1024 extension
		logic       pfe;   // ULA port
		logic [7:0] data;  // CPU data captured with the strobe
	} port_wr_t;

	// ====================
	// Paging state
	// ====================

	typedef struct packed {
		logic [7:0] reg_7ffd;
		logic [7:0] reg_1ffd;
		logic [2:0] page_ext; // upper RAM page bits for 1024K models
		logic       zx48;
		logic       plus3;
		logic       p1024;    // Pentagon 1024
		logic       pf1024;   // Profi 1024
	} paging_t;

	// ====================
	// Memory request
	// ====================

	// Toward external memory
	typedef struct packed {
		logic [zx_arch_pkg::RAM_ADDR_W-1:0] addr;
		logic                               we;
		logic                               rd;
	} mem_req_t;

endpackage

/* common/zx_arch_pkg.sv */
// Spectrum architecture constants: memory model codes, fixed banks and address widths
package zx_arch_pkg;

	// ====================
	// Memory models
	// ====================

	// Code comes straight from the machine select input
	typedef enum logic [2:0] {
		ZX128     = 3'd0, // Spectrum 128K/+2
		PENT1024  = 3'd1, // Pentagon 1024
		PROFI1024 = 3'd2, // Profi 1024
		ZX48      = 3'd3, // Spectrum 48K, paging locked
		PLUS3     = 3'd4  // Spectrum +2A/+3
	} model_t;

	// ====================
	// Address widths
	// ====================

	// External memory address, ROM region sits on top of 1 MB of RAM
	localparam int RAM_ADDR_W = 21;

	// Offset inside one 16K page
	localparam int PAGE_W = 14;

	// ====================
	// Banks and regions
	// ====================

	// Top three address bits of every ROM access
	localparam logic [2:0] ROM_REGION = 3'd5;

	// Fixed RAM pages in the middle quadrants
	localparam logic [2:0] BANK_SCREEN = 3'd5; // 4000h
	localparam logic [2:0] BANK_MID    = 3'd2; // 8000h

	// ROM bank prefixes
	// 128K/+2 and derivatives use banks 6 and 7, low bit picks 48K BASIC
	localparam logic [2:0] ROM_128_BASE = 3'b011;

	// +3 uses banks 8..11, two select bits come from 1FFD and 7FFD
	localparam logic [1:0] ROM_PLUS3_BASE = 2'b10;

endpackage
